//--- list.f
+incdir+.
main_pkg.sv
main_ram.sv
main_decode.sv
main_io_regs.sv
main_bus_ctrl.sv
main_top.sv
main_tb.sv

//--- main_bus_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module main_bus_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    rst8,
    input  logic                    req_valid,
    input  main_pkg::bus_req_t      req,
    output logic                    req_ready,
    output main_pkg::bus_req_t      cur_req,
    input  main_pkg::chip_sel_t     sel,
    input  logic [7:0]              rdata,
    input  logic                    rom_ok,
    output logic                    rom_cs,
    output logic                    wr_ram,
    output logic                    wr_pal,
    output logic                    io_stb,
    output logic                    resp_valid,
    output main_pkg::bus_resp_t     resp
);

    typedef enum logic [1:0] {
        st_idle,
        st_access,
        st_rom_wait,
        st_resp
    } state_t;

    state_t state;
    logic   run_q;
    logic   accept;
    logic   done;

    // run_q keeps the port closed while rst is high
    // a pending response blocks the next request for one cycle
    assign req_ready = state == st_idle && !resp_valid && !rst8 && run_q;
    assign accept    = req_valid && req_ready;

    // rom select held through the whole wait
    assign rom_cs = sel.rom && (state == st_access || state == st_rom_wait);

    // one-cycle strobes, only in the access cycle
    assign wr_ram = state == st_access && cur_req.we && sel.ram;
    assign wr_pal = state == st_access && cur_req.we && sel.pal;
    assign io_stb = state == st_access && sel.io;

    // read byte valid now
    // rom as soon as ok comes back, others one cycle after access
    assign done = !rst8 && (state == st_resp || (rom_cs && rom_ok));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= st_idle;
            resp_valid <= 1'b0;
            run_q      <= 1'b0;
        end else begin
            run_q      <= 1'b1;
            resp_valid <= done;
            if (rst8) begin
                // video sub-reset aborts whatever is going on
                state <= st_idle;
            end else begin
                case (state)
                    st_idle: begin
                        if (accept) begin
                            state <= st_access;
                        end
                    end
                    st_access: begin
                        if (!sel.rom) begin
                            // ram read or port capture happens on this edge
                            state <= st_resp;
                        end else if (rom_ok) begin
                            state <= st_idle;
                        end else begin
                            state <= st_rom_wait;
                        end
                    end
                    st_rom_wait: begin
                        if (rom_ok) begin
                            state <= st_idle;
                        end
                    end
                    default: begin
                        state <= st_idle;
                    end
                endcase
            end
        end
    end

    // request and response payload
    always_ff @(posedge clk) begin
        if (accept) begin
            cur_req <= req;
        end
        if (done) begin
            resp.rdata     <= rdata;
            resp.was_write <= cur_req.we;
        end
    end

endmodule

`default_nettype wire

//--- main_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "main_defs.svh"

module main_decode (
    input  main_pkg::bus_req_t          req,
    input  main_pkg::main_ctrl_t        ctrl,
    output main_pkg::chip_sel_t         sel,
    output logic [`MAIN_ROM_AW-1:0]     rom_addr,
    input  logic [7:0]                  rom_data,
    input  logic [7:0]                  ram_dout,
    input  logic [7:0]                  pal_dout,
    input  logic [7:0]                  port_dout,
    input  logic [7:0]                  tilesys_dout,
    input  logic [7:0]                  objsys_dout,
    output logic [7:0]                  rdata
);

    // first stage, A[15:13] plus the work bit
    always_comb begin
        // banked window 2000-3fff
        sel.banked = req.addr[15:13] == 3'b001;
        // fixed program from 8000 up
        sel.rom    = req.addr[15] || sel.banked;
        // low 1 kB is lost to palette while work is set
        sel.ram    = req.addr[15:13] == 3'b000 &&
                     (req.addr[12] || req.addr[11] || req.addr[10] || !ctrl.work);
        sel.pal    = req.addr[15:10] == 6'd0 && ctrl.work;
    end

    // second stage, finer video and io area split
    always_comb begin
        // 5f80-5f9f
        sel.io      = req.addr[15:7] == 9'b0101_1111_1 && req.addr[6:5] == 2'b00;
        // 7c00-7fff, or the few bytes at 7800
        sel.objsys  = req.addr[15:11] == 5'b01111 && !ctrl.rmrd && ctrl.init &&
                      (req.addr[10] || req.addr[9:3] == 7'd0);
        // everything else in 4000-7fff
        // before init the tile chip owns the whole window
        sel.tilesys = req.addr[15:14] == 2'b01 &&
                      (!ctrl.init || (!sel.io && !sel.pal && !sel.objsys));
    end

    // rom address forming
    // banked: five bank bits over the 8 kB window offset
    // fixed: constant prefix over the full CPU address
    always_comb begin
        if (sel.banked) begin
            rom_addr = {req.addr_hi[4:0], req.addr[12:0]};
        end else begin
            rom_addr = {`MAIN_ROM_FIX, req.addr};
        end
    end

    // read data, first match wins
    // io ahead of tile since they overlap before init
    always_comb begin
        if (sel.rom) begin
            rdata = rom_data;
        end else if (sel.ram) begin
            rdata = ram_dout;
        end else if (sel.io) begin
            rdata = port_dout;
        end else if (sel.pal) begin
            rdata = pal_dout;
        end else if (sel.tilesys) begin
            rdata = tilesys_dout;
        end else if (sel.objsys) begin
            rdata = objsys_dout;
        end else begin
            // open bus
            rdata = 8'hff;
        end
    end

endmodule

`default_nettype wire

//--- main_defs.svh
`ifndef MAIN_DEFS_SVH
`define MAIN_DEFS_SVH

// program ROM word address width
// 18 bits covers 256 kB of byte-wide ROM
`define MAIN_ROM_AW 18

// bits placed above the 16-bit CPU address for fixed ROM
// fixed area sits at 20000-2FFFF of the ROM space
`define MAIN_ROM_FIX 2'b10

// work RAM, 8 kB
`define MAIN_WRAM_AW 13

// palette RAM, 1 kB
`define MAIN_PAL_AW 10

// DIP switch bank width
// three 8-bit banks, only four bits of the top one used
`define MAIN_DIP_W 20

`endif

//--- main_io_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "main_defs.svh"

module main_io_regs (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        io_stb,
    input  logic                        we,
    input  logic [3:0]                  offset,
    input  logic [7:0]                  wdata,
    input  main_pkg::cabinet_t          cab,
    input  logic [`MAIN_DIP_W-1:0]      dipsw,
    input  logic                        snd_ack,
    output main_pkg::main_ctrl_t        ctrl,
    output logic [7:0]                  snd_latch,
    output logic                        snd_irq,
    output logic [7:0]                  port_dout
);

    logic rd_stb;
    logic wr_stb;

    assign rd_stb = io_stb && !we;
    assign wr_stb = io_stb && we;

    // input port capture
    // value held until the next io read
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            port_dout <= 8'd0;
        end else if (rd_stb) begin
            case (offset)
                // upper bits float high on the board
                4'h0: port_dout <= {3'b111, cab.service, dipsw[19:16]};
                4'h1: port_dout <= {cab.start[0], cab.coin[0], cab.joy1};
                4'h2: port_dout <= {cab.start[1], cab.coin[1], cab.joy2};
                4'h3: port_dout <= dipsw[15:8];
                4'h4: port_dout <= dipsw[7:0];
                default: port_dout <= 8'hff;
            endcase
        end
    end

    // control bits at offset 8
    // bits 1..0 there drive the coin counters, not kept here
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ctrl <= '0;
        end else if (wr_stb && offset == 4'h8) begin
            ctrl <= main_pkg::main_ctrl_t'(wdata[7:5]);
        end
    end

    // sound latch and its interrupt
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            snd_latch <= 8'd0;
            snd_irq   <= 1'b0;
        end else begin
            // ack seen this cycle, line drops next
            if (snd_ack) begin
                snd_irq <= 1'b0;
            end
            // a new command wins over a same-cycle ack
            if (wr_stb && offset == 4'hc) begin
                snd_latch <= wdata;
                snd_irq   <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- main_pkg.sv
`default_nettype none

package main_pkg;

    // one CPU access as issued by the bus master
    // addr_hi carries the bank bits
    typedef struct packed {
        logic [7:0]  addr_hi;
        logic [15:0] addr;
        logic        we;
        logic [7:0]  wdata;
    } bus_req_t;

    // completed access returned to the master
    typedef struct packed {
        logic [7:0] rdata;
        logic       was_write;
    } bus_resp_t;

    // chip selects from the address decoder
    // io and tilesys may both be set, read priority sorts it out
    typedef struct packed {
        logic rom;
        logic banked;
        logic ram;
        logic io;
        logic pal;
        logic tilesys;
        logic objsys;
    } chip_sel_t;

    // control bits written at io offset 8, data bits 7..5
    // init enables the full video map
    // rmrd routes 7800 reads to the tile chip
    // work swaps 0000-03ff over to palette
    typedef struct packed {
        logic init;
        logic rmrd;
        logic work;
    } main_ctrl_t;

    // cabinet inputs, bit 0 of start/coin is player 1
    typedef struct packed {
        logic [1:0] start;
        logic [1:0] coin;
        logic [5:0] joy1;
        logic [5:0] joy2;
        logic       service;
    } cabinet_t;

endpackage

`default_nettype wire

//--- main_ram.sv
`timescale 1ns/1ps
`default_nettype none

module main_ram #(
    parameter int aw = 10
) (
    input  logic            clk,
    input  logic            we,
    input  logic [aw-1:0]   addr,
    input  logic [7:0]      din,
    output logic [7:0]      dout
);

    // byte array, maps onto block RAM
    logic [7:0] mem [0:(1 << aw) - 1];

    // write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= din;
        end
    end

    // registered read, old data on a same-cycle write
    always_ff @(posedge clk) begin
        dout <= mem[addr];
    end

endmodule

`default_nettype wire

//--- main_stim.txt
# kind addr_hi addr we wdata expect (hex except kind)
# kind 0 access, 1 rst8 pulse (wdata = cycles), 2 snd_ack, 3 ctrl check, 4 sound check
0 05 2345 0 00 e6
0 1f 3fff 0 00 03
0 00 c3a5 0 00 64
0 07 ffff 0 00 02
0 00 0123 1 5a 00
0 00 0400 1 11 00
0 00 0123 0 00 5a
0 00 5f80 0 00 f9
0 00 5f81 0 00 6b
0 00 5f82 0 00 94
0 00 5f83 0 00 c6
0 00 5f84 0 00 3e
0 00 5f85 0 00 ff
0 00 7800 0 00 a5
0 00 5f8c 1 9d 00
4 00 0000 0 9d 01
2 00 0000 0 00 00
4 00 0000 0 9d 00
0 00 5f88 1 20 00
0 00 0123 1 e1 00
0 00 0123 0 00 e1
0 00 0400 0 00 11
0 00 5f88 1 00 00
0 00 0123 0 00 5a
0 00 5f88 1 80 00
3 00 0000 0 00 04
0 00 7800 0 00 3c
0 00 5000 0 00 a5
0 00 5f88 1 c0 00
0 00 7800 0 00 a5
1 00 0000 0 03 00
0 00 0123 0 00 5a
3 00 0000 0 00 06
0 00 8000 0 00 82

//--- main_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "main_defs.svh"

module main_tb;

    localparam time clk_period = 4;

    // one parsed stimulus line
    typedef struct packed {
        logic [3:0]         kind;
        main_pkg::bus_req_t req;
        logic [7:0]         exp_val;
    } stim_t;

    logic                       clk;
    logic                       rst;
    logic                       rst8;
    logic                       req_valid;
    main_pkg::bus_req_t         req;
    logic                       req_ready;
    logic                       resp_valid;
    main_pkg::bus_resp_t        resp;
    logic [`MAIN_ROM_AW-1:0]    rom_addr;
    logic                       rom_cs;
    logic [7:0]                 rom_data;
    logic                       rom_ok;
    main_pkg::cabinet_t         cab;
    logic [`MAIN_DIP_W-1:0]     dipsw;
    logic                       snd_ack;
    logic [7:0]                 snd_latch;
    logic                       snd_irq;
    main_pkg::main_ctrl_t       ctrl;

    stim_t  stim_q[$];
    int     n_ops = 0;
    integer seed = 32'h7310_de44;
    // last rising edge of rom_ok
    time    rom_ok_time = 0;

    // start 10, coin 01, joy1 2b, joy2 14, service 1
    assign cab   = 17'b10_01_101011_010100_1;
    assign dipsw = 20'h9_c63e;

    // rom byte is byte 0 ^ byte 1 ^ the top two address bits
    assign rom_data = rom_addr[7:0] ^ rom_addr[15:8] ^ {6'd0, rom_addr[17:16]};

    main_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .rst8         (rst8),
        .req_valid    (req_valid),
        .req          (req),
        .req_ready    (req_ready),
        .resp_valid   (resp_valid),
        .resp         (resp),
        .rom_addr     (rom_addr),
        .rom_cs       (rom_cs),
        .rom_data     (rom_data),
        .rom_ok       (rom_ok),
        .cab          (cab),
        .dipsw        (dipsw),
        .tilesys_dout (8'ha5),
        .objsys_dout  (8'h3c),
        .snd_ack      (snd_ack),
        .snd_latch    (snd_latch),
        .snd_irq      (snd_irq),
        .ctrl         (ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // rom ok after 0..5 falling edges of rom_cs
    initial begin : rom_model
        int wait_left;
        rom_ok    = 1'b0;
        wait_left = -1;
        forever begin
            @(negedge clk);
            if (rom_cs !== 1'b1) begin
                rom_ok    = 1'b0;
                wait_left = -1;
            end else begin
                if (wait_left < 0) begin
                    wait_left = $unsigned($random(seed)) % 6;
                end
                if (wait_left == 0) begin
                    if (rom_ok !== 1'b1) begin
                        rom_ok_time = $time;
                    end
                    rom_ok = 1'b1;
                end else begin
                    wait_left = wait_left - 1;
                end
            end
        end
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1);
    endtask

    // rdata of a write is whatever the mux held and only was_write counts there
    task automatic check_resp(input main_pkg::bus_resp_t got, input main_pkg::bus_resp_t want,
                              input logic data_checked);
        if (got.was_write !== want.was_write) begin
            abort_run($sformatf("ERROR resp.was_write got 0x%0h expected 0x%0h",
                                got.was_write, want.was_write));
        end else if (data_checked && got.rdata !== want.rdata) begin
            abort_run($sformatf("ERROR resp.rdata got 0x%02h expected 0x%02h",
                                got.rdata, want.rdata));
        end
    endtask

    task automatic check_ctrl(input main_pkg::main_ctrl_t got, input main_pkg::main_ctrl_t want);
        if (got !== want) begin
            abort_run($sformatf("ERROR ctrl got 0x%0h expected 0x%0h", got, want));
        end
    endtask

    task automatic check_snd(input logic [7:0] latch_got, input logic irq_got,
                             input logic [7:0] latch_exp, input logic irq_exp);
        if (latch_got !== latch_exp) begin
            abort_run($sformatf("ERROR snd_latch got 0x%02h expected 0x%02h",
                                latch_got, latch_exp));
        end else if (irq_got !== irq_exp) begin
            abort_run($sformatf("ERROR snd_irq got 0x%0h expected 0x%0h", irq_got, irq_exp));
        end
    endtask

    // banked window and fixed program area
    function automatic logic in_rom_window(input logic [15:0] addr);
        return addr >= 16'h8000 || (addr >= 16'h2000 && addr < 16'h4000);
    endfunction

    task automatic load_stim();
        int     fd;
        int     cnt;
        int     kind;
        int     ahi;
        int     addr;
        int     we;
        int     wd;
        int     ev;
        string  line;
        stim_t  s;
        fd = $fopen("main_stim.txt", "r");
        if (fd == 0) begin
            abort_run("could not open main_stim.txt for reading");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // skip blank lines and '#' comments
                if (line.len() >= 2 && line.getc(0) != 8'h23) begin
                    cnt = $sscanf(line, "%d %h %h %h %h %h", kind, ahi, addr, we, wd, ev);
                    if (cnt != 6) begin
                        abort_run({"malformed stimulus line: ", line});
                    end
                    s.kind          = kind[3:0];
                    s.req.addr_hi   = ahi[7:0];
                    s.req.addr      = addr[15:0];
                    s.req.we        = we[0];
                    s.req.wdata     = wd[7:0];
                    s.exp_val       = ev[7:0];
                    stim_q.push_back(s);
                end
            end
            $fclose(fd);
        end
    endtask

    // called on a falling edge and returns on the one that shows resp_valid
    // lat counts whole cycles from the accepting edge
    task automatic run_access(input main_pkg::bus_req_t r, output main_pkg::bus_resp_t got,
                              output int lat);
        req_valid = 1'b1;
        req       = r;
        while (!req_ready) begin
            @(negedge clk);
        end
        // accepted on the rising edge in between
        @(negedge clk);
        req_valid = 1'b0;
        lat       = 0;
        while (!resp_valid) begin
            @(negedge clk);
            lat = lat + 1;
        end
        got = resp;
    endtask

    task automatic pulse_rst8(input int cycles);
        rst8 = 1'b1;
        repeat (cycles) begin
            @(negedge clk);
            if (req_ready) begin
                abort_run("req_ready went high while rst8 was active");
            end
        end
        rst8 = 1'b0;
    endtask

    // budget of 40 cycles per stimulus line plus reset
    initial begin : watchdog
        wait (n_ops > 0);
        repeat (n_ops * 40 + 10) begin
            @(posedge clk);
        end
        abort_run("timeout: the stimulus did not finish within its cycle budget");
    end

    initial begin : stimulus
        main_pkg::bus_resp_t got;
        main_pkg::bus_resp_t want;
        int                  lat;
        time                 ok_gap;
        stim_t               s;
        rst       = 1'b1;
        rst8      = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        snd_ack   = 1'b0;
        load_stim();
        if (stim_q.size() == 0) begin
            abort_run("main_stim.txt holds no stimulus lines");
        end
        n_ops = stim_q.size();
        repeat (5) begin
            @(posedge clk);
        end
        @(negedge clk);
        rst = 1'b0;
        foreach (stim_q[i]) begin
            s = stim_q[i];
            case (s.kind)
                4'd0: begin
                    run_access(s.req, got, lat);
                    want.rdata     = s.exp_val;
                    want.was_write = s.req.we;
                    check_resp(got, want, !s.req.we);
                    if (in_rom_window(s.req.addr)) begin
                        // response one cycle after rom_ok met rom_cs
                        ok_gap = $time - rom_ok_time;
                        if (ok_gap != clk_period) begin
                            abort_run($sformatf(
                                "rom read at %04h answered %0d ns after rom_ok, not one cycle",
                                s.req.addr, ok_gap));
                        end
                    end else if (lat != 2) begin
                        // outside the rom windows the latency is fixed
                        abort_run($sformatf("access to %04h took %0d cycles instead of 2",
                                            s.req.addr, lat));
                    end
                end
                4'd1: pulse_rst8(int'(s.req.wdata));
                4'd2: begin
                    snd_ack = 1'b1;
                    @(negedge clk);
                    snd_ack = 1'b0;
                end
                4'd3: check_ctrl(ctrl, main_pkg::main_ctrl_t'(s.exp_val[2:0]));
                4'd4: check_snd(snd_latch, snd_irq, s.req.wdata, s.exp_val[0]);
                default: abort_run($sformatf("unknown stimulus kind %0d", s.kind));
            endcase
        end
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

//--- main_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "main_defs.svh"

module main_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        rst8,
    // bus master
    input  logic                        req_valid,
    input  main_pkg::bus_req_t          req,
    output logic                        req_ready,
    output logic                        resp_valid,
    output main_pkg::bus_resp_t         resp,
    // program rom
    output logic [`MAIN_ROM_AW-1:0]     rom_addr,
    output logic                        rom_cs,
    input  logic [7:0]                  rom_data,
    input  logic                        rom_ok,
    // cabinet
    input  main_pkg::cabinet_t          cab,
    input  logic [`MAIN_DIP_W-1:0]      dipsw,
    // video read data
    input  logic [7:0]                  tilesys_dout,
    input  logic [7:0]                  objsys_dout,
    // sound cpu
    input  logic                        snd_ack,
    output logic [7:0]                  snd_latch,
    output logic                        snd_irq,
    output main_pkg::main_ctrl_t        ctrl
);

    main_pkg::bus_req_t     cur_req;
    main_pkg::chip_sel_t    sel;
    logic [7:0]             rdata;
    logic [7:0]             ram_dout;
    logic [7:0]             pal_dout;
    logic [7:0]             port_dout;
    logic                   wr_ram;
    logic                   wr_pal;
    logic                   io_stb;

    main_bus_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .rst8       (rst8),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .cur_req    (cur_req),
        .sel        (sel),
        .rdata      (rdata),
        .rom_ok     (rom_ok),
        .rom_cs     (rom_cs),
        .wr_ram     (wr_ram),
        .wr_pal     (wr_pal),
        .io_stb     (io_stb),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    main_decode u_decode (
        .req          (cur_req),
        .ctrl         (ctrl),
        .sel          (sel),
        .rom_addr     (rom_addr),
        .rom_data     (rom_data),
        .ram_dout     (ram_dout),
        .pal_dout     (pal_dout),
        .port_dout    (port_dout),
        .tilesys_dout (tilesys_dout),
        .objsys_dout  (objsys_dout),
        .rdata        (rdata)
    );

    // io window is 32 bytes, only the low nibble decodes
    main_io_regs u_io (
        .clk       (clk),
        .rst       (rst),
        .io_stb    (io_stb),
        .we        (cur_req.we),
        .offset    (cur_req.addr[3:0]),
        .wdata     (cur_req.wdata),
        .cab       (cab),
        .dipsw     (dipsw),
        .snd_ack   (snd_ack),
        .ctrl      (ctrl),
        .snd_latch (snd_latch),
        .snd_irq   (snd_irq),
        .port_dout (port_dout)
    );

    // work ram 0000-1fff
    main_ram #(.aw(`MAIN_WRAM_AW)) u_wram (
        .clk  (clk),
        .we   (wr_ram),
        .addr (cur_req.addr[`MAIN_WRAM_AW-1:0]),
        .din  (cur_req.wdata),
        .dout (ram_dout)
    );

    // palette, shadows the bottom of work ram
    main_ram #(.aw(`MAIN_PAL_AW)) u_pal (
        .clk  (clk),
        .we   (wr_pal),
        .addr (cur_req.addr[`MAIN_PAL_AW-1:0]),
        .din  (cur_req.wdata),
        .dout (pal_dout)
    );

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the main bus testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module main_tb -f list.f -o sim_main
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_main 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qF '** PASS **'; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
